// File: include/hacd_define.svh
// ##################
// AXI read channel widths, included by the package and the read interface
// ##################

`ifndef HACD_DEFINE_SVH
`define HACD_DEFINE_SVH

// byte address of one read request
`define HACD_AXI4_ADDR_WIDTH 64

// one beat carries a full 64-byte cache line
`define HACD_AXI4_DATA_WIDTH 512

// okay / exokay / slverr / decerr
`define HACD_AXI4_RESP_WIDTH 2

`endif

// File: hw/hacd_pkg.sv
// ##################
// shared widths, table bases, types and FSM states of the page-read manager
// import into any module that needs them
// ##################

`default_nettype none

`include "hacd_define.svh"

package hacd_pkg;

	// axi channel widths
	localparam int unsigned AXI_ADDR_W = `HACD_AXI4_ADDR_WIDTH;
	localparam int unsigned AXI_DATA_W = `HACD_AXI4_DATA_WIDTH;
	localparam int unsigned AXI_RESP_W = `HACD_AXI4_RESP_WIDTH;

	// table sizes, entry ids start at 1
	localparam int unsigned ATT_ENTRY_MAX = 65536;
	localparam int unsigned LST_ENTRY_MAX = 16384;
	localparam int unsigned ATT_ID_W = $clog2(ATT_ENTRY_MAX);
	localparam int unsigned LST_ID_W = $clog2(LST_ENTRY_MAX);

	// host page number is the byte address above the 4k offset
	localparam int unsigned PAGE_SHIFT = 12;
	localparam int unsigned HPPA_W = AXI_ADDR_W - PAGE_SHIFT;

	// ppa field sits in entry bits 49..2
	localparam int unsigned PPA_W = 48;

	// four list entries per cache line
	localparam int unsigned LST_ENTRY_W = 128;

	// response watchdog
	localparam int unsigned RD_TIMEOUT_CYCLES = 64;
	localparam int unsigned TIMER_WIDTH = 7;

	// vector types
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [AXI_RESP_W-1:0] axi_resp_t;
	typedef logic [HPPA_W-1:0] hppa_t;
	typedef logic [PPA_W-1:0] ppa_t;
	typedef logic [ATT_ID_W-1:0] att_id_t;
	typedef logic [LST_ID_W-1:0] lst_id_t;
	typedef logic [LST_ENTRY_W-1:0] lst_entry_t;

	// first host page mapped by the att
	localparam hppa_t HPPA_BASE_PAGE = 52'h0_0000_0008_0000;

	// table locations in compressed memory
	localparam axi_addr_t HAWK_ATT_START = 64'h0000_0000_c000_0000;
	localparam axi_addr_t HAWK_LIST_START = 64'h0000_0000_c800_0000;

	// att entry status, bits 63..62 of an entry
	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1,
		STS_INCOMP = 2'd2,
		STS_COMP   = 2'd3
	} att_sts_t;

	// list names used by the table update
	typedef enum logic [1:0] {
		FREE   = 2'd0,
		UNCOMP = 2'd1
	} list_id_e;

	// page-read sequence
	typedef enum logic [3:0] {
		IDLE             = 4'd0,
		LOOKUP_ATT       = 4'd1,
		WAIT_ATT_ENTRY   = 4'd2,
		DECODE_ATT_ENTRY = 4'd3,
		POP_FREE_LST     = 4'd4,
		WAIT_LST_ENTRY   = 4'd5,
		ALLOCATE_PPA     = 4'd6,
		TBL_UPDATE       = 4'd7,
		UNCOMPRESS       = 4'd8,
		BUS_ERROR        = 4'd9
	} pgrd_state_e;

endpackage

`default_nettype wire

// File: hw/axi_rd_if.sv
// ##################
// single-beat AXI read channel between FSM, datapath and top
// ##################

`default_nettype none

`include "hacd_define.svh"

interface axi_rd_if;

	// request
	logic [`HACD_AXI4_ADDR_WIDTH-1:0] addr;
	logic arvalid;
	logic arready;

	// response, one beat per request
	logic rvalid;
	logic rlast;
	logic [`HACD_AXI4_RESP_WIDTH-1:0] rresp;
	logic [`HACD_AXI4_DATA_WIDTH-1:0] rdata;
	logic rready;

	// handshake side
	modport fsm (output arvalid, rready, input arready, rvalid, rlast, rresp);

	// address and data side
	modport dp (output addr, input rvalid, rdata);

	// memory facing pins
	modport top (input addr, arvalid, rready, output arready, rvalid, rlast, rresp, rdata);

endinterface

`default_nettype wire

// File: hw/pgrd_fsm.sv
// ##################
// sequencing FSM of the page-read manager
// drives the read handshake and the datapath load strobes
// ##################

`default_nettype none

module pgrd_fsm
	import hacd_pkg::*;
(
	input  logic clk_i,
	input  logic rst_ni,
	input  logic lookup,
	input  logic pgwr_mngr_ready,
	input  lst_id_t free_lst_head,
	input  lst_id_t free_lst_tail,
	input  att_sts_t att_sts,
	input  logic timeout,
	axi_rd_if.fsm axi,
	output logic att_addr_ld,
	output logic lst_addr_ld,
	output logic rdata_ld,
	output logic decode_en,
	output logic grant,
	output logic upd_ld,
	output logic upd_fire,
	output logic wait_rsp,
	output logic pgrd_mngr_ready,
	output logic bus_error
);

	pgrd_state_e state_q;
	pgrd_state_e state_d;
	logic arvalid_q;
	logic arvalid_d;
	logic rready_q;
	logic free_empty;
	logic beat;
	logic rsp_ok;

	// head catching up with tail means nothing left to pop
	assign free_empty = (free_lst_head == free_lst_tail);

	// single-beat bursts, a response is the last beat
	assign beat = axi.rvalid && axi.rlast;
	assign rsp_ok = (axi.rresp == '0);

	always_comb begin
		state_d = state_q;
		arvalid_d = 1'b0;
		att_addr_ld = 1'b0;
		lst_addr_ld = 1'b0;
		rdata_ld = 1'b0;
		decode_en = 1'b0;
		grant = 1'b0;
		upd_ld = 1'b0;
		upd_fire = 1'b0;

		unique case (state_q)
			IDLE: begin
				// att id and line address latched with the request
				if (lookup) begin
					att_addr_ld = 1'b1;
					state_d = LOOKUP_ATT;
				end
			end
			LOOKUP_ATT: begin
				if (axi.arready && !arvalid_q) begin
					arvalid_d = 1'b1;
					state_d = WAIT_ATT_ENTRY;
				end
			end
			WAIT_ATT_ENTRY: begin
				if (beat) begin
					rdata_ld = rsp_ok;
					state_d = rsp_ok ? DECODE_ATT_ENTRY : BUS_ERROR;
				end else if (timeout) begin
					state_d = BUS_ERROR;
				end
			end
			DECODE_ATT_ENTRY: begin
				decode_en = 1'b1;
				unique case (att_sts)
					STS_UNCOMP, STS_INCOMP: begin
						// hit, translation goes straight out
						grant = 1'b1;
						state_d = IDLE;
					end
					// compressed page, decompression not present
					STS_COMP: state_d = UNCOMPRESS;
					default: state_d = POP_FREE_LST;
				endcase
			end
			POP_FREE_LST: begin
				if (free_empty) begin
					// no victim search, just give up the request
					state_d = IDLE;
				end else if (axi.arready && !arvalid_q) begin
					lst_addr_ld = 1'b1;
					arvalid_d = 1'b1;
					state_d = WAIT_LST_ENTRY;
				end
			end
			WAIT_LST_ENTRY: begin
				if (beat) begin
					rdata_ld = rsp_ok;
					state_d = rsp_ok ? ALLOCATE_PPA : BUS_ERROR;
				end else if (timeout) begin
					state_d = BUS_ERROR;
				end
			end
			ALLOCATE_PPA: begin
				// build the packet, send at once if the writer is ready
				upd_ld = 1'b1;
				if (pgwr_mngr_ready) begin
					upd_fire = 1'b1;
					state_d = IDLE;
				end else begin
					state_d = TBL_UPDATE;
				end
			end
			TBL_UPDATE: begin
				// packet held until the writer takes it
				if (pgwr_mngr_ready) begin
					upd_fire = 1'b1;
					state_d = IDLE;
				end
			end
			// both sticky until reset
			UNCOMPRESS: state_d = UNCOMPRESS;
			BUS_ERROR: state_d = BUS_ERROR;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
			arvalid_q <= 1'b0;
			rready_q <= 1'b0;
		end else begin
			state_q <= state_d;
			arvalid_q <= arvalid_d;
			// never stall the response channel
			rready_q <= 1'b1;
		end
	end

	assign axi.arvalid = arvalid_q;
	assign axi.rready = rready_q;

	// watchdog runs only while a response is outstanding
	assign wait_rsp = (state_q == WAIT_ATT_ENTRY) || (state_q == WAIT_LST_ENTRY);

	assign pgrd_mngr_ready = (state_q == IDLE);
	assign bus_error = (state_q == BUS_ERROR);

	// memory side must close every burst in one beat
	a_rlast_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
		axi.rvalid |-> axi.rlast);

	// request strobe is a single-cycle pulse
	a_arvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
		axi.arvalid |=> !axi.arvalid);

endmodule

`default_nettype wire

// File: hw/rd_timeout_timer.sv
// ##################
// read response watchdog, counts while a response is awaited
// ##################

`default_nettype none

module rd_timeout_timer
	import hacd_pkg::*;
(
	input  logic clk_i,
	input  logic rst_ni,
	input  logic wait_rsp,
	output logic timeout
);

	logic [TIMER_WIDTH-1:0] cnt_q;
	logic at_limit;

	assign at_limit = (cnt_q == TIMER_WIDTH'(RD_TIMEOUT_CYCLES));

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			cnt_q <= '0;
		end else if (!wait_rsp) begin
			// back to zero between requests
			cnt_q <= '0;
		end else if (!at_limit) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// held at the limit until the FSM leaves the wait state
	assign timeout = at_limit;

	// saturation must stop the count at the limit
	a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
		cnt_q <= TIMER_WIDTH'(RD_TIMEOUT_CYCLES));

endmodule

`default_nettype wire

// File: hw/pgrd_datapath.sv
// ##################
// address generation, line capture, ATT decode and output packets
// loaded by the strobes of the page-read FSM
// ##################

`default_nettype none

module pgrd_datapath
	import hacd_pkg::*;
(
	input  logic clk_i,
	input  logic rst_ni,
	input  hppa_t hppa,
	input  lst_id_t free_lst_head,
	input  logic att_addr_ld,
	input  logic lst_addr_ld,
	input  logic rdata_ld,
	input  logic decode_en,
	input  logic grant,
	input  logic upd_ld,
	input  logic upd_fire,
	axi_rd_if.dp axi,
	output att_sts_t att_sts,
	output logic allow_access,
	output ppa_t ppa,
	output att_sts_t sts,
	output logic tbl_update,
	output att_id_t upd_att_id,
	output lst_id_t upd_tol_id,
	output list_id_e upd_src_list,
	output list_id_e upd_dst_list,
	output lst_entry_t upd_lst_entry
);

	att_id_t att_id_d;
	att_id_t att_id_q;
	att_id_t att_id_m1;
	lst_id_t head_m1;
	logic [2:0] word_sel_q;
	axi_addr_t att_line_addr;
	axi_addr_t lst_line_addr;
	axi_addr_t addr_q;
	axi_data_t line_q;
	logic [63:0] att_entry;
	lst_entry_t lst_entry;

	// memory holds each 8-byte word byte-reversed
	function automatic axi_data_t swap_8byte(input axi_data_t din);
		axi_data_t dout;
		for (int w = 0; w < 8; w++) begin
			for (int b = 0; b < 8; b++) begin
				dout[64*w + 8*b +: 8] = din[64*w + 8*(7-b) +: 8];
			end
		end
		return dout;
	endfunction

	// ids start at 1
	assign att_id_d = att_id_t'(hppa - HPPA_BASE_PAGE + hppa_t'(1));
	assign att_id_m1 = att_id_d - att_id_t'(1);
	assign head_m1 = free_lst_head - lst_id_t'(1);

	// eight att entries or four list entries per 64-byte line
	assign att_line_addr = HAWK_ATT_START + (axi_addr_t'(att_id_m1 >> 3) << 6);
	assign lst_line_addr = HAWK_LIST_START + (axi_addr_t'(head_m1 >> 2) << 6);

	// entry picked by the low page bits
	assign att_entry = line_q[64*word_sel_q +: 64];
	assign att_sts = att_sts_t'(att_entry[63:62]);

	// head 1 is the lowest slot, head 0 wraps to the top
	always_comb begin
		unique case (free_lst_head[1:0])
			2'b01: lst_entry = line_q[127:0];
			2'b10: lst_entry = line_q[255:128];
			2'b11: lst_entry = line_q[383:256];
			default: lst_entry = line_q[511:384];
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			allow_access <= 1'b0;
			tbl_update <= 1'b0;
		end else begin
			allow_access <= grant;
			tbl_update <= upd_fire;
		end
	end

	always_ff @(posedge clk_i) begin
		if (att_addr_ld) begin
			att_id_q <= att_id_d;
			word_sel_q <= hppa[2:0];
			addr_q <= att_line_addr;
		end else if (lst_addr_ld) begin
			addr_q <= lst_line_addr;
		end
		if (rdata_ld && axi.rvalid)
			line_q <= swap_8byte(axi.rdata);
		// translation holds until the next decode
		if (decode_en) begin
			ppa <= att_entry[49:2];
			sts <= att_sts;
		end
		// freed page moves from the free list to the uncompressed list
		if (upd_ld) begin
			upd_att_id <= att_id_q;
			upd_tol_id <= free_lst_head;
			upd_src_list <= FREE;
			upd_dst_list <= UNCOMP;
			upd_lst_entry <= lst_entry;
		end
	end

	assign axi.addr = addr_q;

endmodule

`default_nettype wire

// File: hw/hawk_pgrd_mngr.sv
// ##################
// page-read manager top, plain AXI read and table update ports
// ##################

`default_nettype none

module hawk_pgrd_mngr
	import hacd_pkg::*;
(
	input  logic clk_i,
	input  logic rst_ni,
	input  logic lookup,
	input  hppa_t hppa,
	input  logic pgwr_mngr_ready,
	input  lst_id_t free_lst_head,
	input  lst_id_t free_lst_tail,
	input  logic arready,
	input  logic rvalid,
	input  logic rlast,
	input  axi_resp_t rresp,
	input  axi_data_t rdata,
	output axi_addr_t araddr,
	output logic arvalid,
	output logic rready,
	output logic allow_access,
	output ppa_t ppa,
	output att_sts_t sts,
	output logic tbl_update,
	output att_id_t upd_att_id,
	output lst_id_t upd_tol_id,
	output list_id_e upd_src_list,
	output list_id_e upd_dst_list,
	output lst_entry_t upd_lst_entry,
	output logic pgrd_mngr_ready,
	output logic bus_error
);

	logic att_addr_ld;
	logic lst_addr_ld;
	logic rdata_ld;
	logic decode_en;
	logic grant;
	logic upd_ld;
	logic upd_fire;
	logic wait_rsp;
	logic timeout;
	att_sts_t att_sts;

	axi_rd_if axi ();

	// memory side of the read channel
	assign axi.arready = arready;
	assign axi.rvalid = rvalid;
	assign axi.rlast = rlast;
	assign axi.rresp = rresp;
	assign axi.rdata = rdata;
	assign araddr = axi.addr;
	assign arvalid = axi.arvalid;
	assign rready = axi.rready;

	pgrd_fsm i_pgrd_fsm (
		.clk_i, .rst_ni, .lookup, .pgwr_mngr_ready, .free_lst_head, .free_lst_tail,
		.att_sts, .timeout, .axi(axi.fsm), .att_addr_ld, .lst_addr_ld, .rdata_ld,
		.decode_en, .grant, .upd_ld, .upd_fire, .wait_rsp, .pgrd_mngr_ready, .bus_error
	);

	rd_timeout_timer i_rd_timeout_timer (.clk_i, .rst_ni, .wait_rsp, .timeout);

	pgrd_datapath i_pgrd_datapath (
		.clk_i, .rst_ni, .hppa, .free_lst_head, .att_addr_ld, .lst_addr_ld, .rdata_ld,
		.decode_en, .grant, .upd_ld, .upd_fire, .axi(axi.dp), .att_sts, .allow_access,
		.ppa, .sts, .tbl_update, .upd_att_id, .upd_tol_id, .upd_src_list, .upd_dst_list,
		.upd_lst_entry
	);

endmodule

`default_nettype wire

// File: tb/tb_hawk_pgrd_mngr.sv
// ##################
// directed testbench of the page-read manager, built from list.f
// plays the memory and the page-write manager
// ##################

`default_nettype none

module tb_hawk_pgrd_mngr
	import hacd_pkg::*;
();

	// memory answers this many cycles after the request
	localparam int RSP_DELAY = 3;
	localparam int REQ_CYCLES = 40;
	localparam int HOLD_CYCLES = 20;
	// 17 lookups, 5 hold windows, one timeout, 9 resets
	localparam int RUN_LIMIT = 2 * (17 * REQ_CYCLES + 5 * HOLD_CYCLES
		+ int'(RD_TIMEOUT_CYCLES) + 9 * 6);

	logic clk_i;
	logic rst_ni;
	logic lookup;
	hppa_t hppa;
	logic pgwr_mngr_ready;
	lst_id_t free_lst_head;
	lst_id_t free_lst_tail;
	logic arready;
	logic rvalid;
	logic rlast;
	axi_resp_t rresp;
	axi_data_t rdata;
	axi_addr_t araddr;
	logic arvalid;
	logic rready;
	logic allow_access;
	ppa_t ppa;
	att_sts_t sts;
	logic tbl_update;
	att_id_t upd_att_id;
	lst_id_t upd_tol_id;
	list_id_e upd_src_list;
	list_id_e upd_dst_list;
	lst_entry_t upd_lst_entry;
	logic pgrd_mngr_ready;
	logic bus_error;

	int seed;
	int errors = 0;
	int cyc = 0;
	// reads counted by the memory model, base taken at each lookup
	int reads_seen = 0;
	int reads_base = 0;
	int att_ar_cyc = 0;
	int att_beat_cyc = 0;
	int lst_ar_cyc = 0;
	int lst_beat_cyc = 0;
	logic drop_rsp;
	axi_resp_t rsp_code;

	// expected values of the current request
	axi_addr_t exp_att_addr;
	axi_addr_t exp_lst_addr;
	logic [2:0] att_word;
	logic [63:0] att_entry;
	logic [1:0] lst_slot;
	lst_entry_t exp_lst_entry;
	att_id_t exp_att_id;
	ppa_t exp_ppa;
	att_sts_t exp_sts;

	hawk_pgrd_mngr i_hawk_pgrd_mngr (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// inputs change and outputs are read just after the rising edge
	task automatic next_cycle();
		@(posedge clk_i);
		#1;
	endtask

	task automatic report_mismatch(input string msg);
		errors++;
		$display("MISMATCH at time %0t: %s", $time, msg);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at time %0t: %s", $time, msg);
	endtask

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// background words, every one tied to the full line address
	function automatic axi_data_t fill_line(input axi_addr_t a);
		axi_data_t line;
		for (int w = 0; w < 8; w++) begin
			line[64*w +: 64] = {a[63:32] ^ a[31:0] ^ 32'h5a5a_0000 ^ 32'(w),
				a[31:0] + 32'(8 * w)};
		end
		return line;
	endfunction

	// memory stores each 8-byte word with its bytes reversed
	function automatic axi_data_t swap_line(input axi_data_t d);
		axi_data_t s;
		for (int w = 0; w < 8; w++) begin
			s[64*w +: 64] = {<<8{d[64*w +: 64]}};
		end
		return s;
	endfunction

	// memory model, first read of a request is the ATT line, second the list line
	initial begin : memory_responder
		axi_addr_t addr;
		axi_data_t line;
		int n;
		arready = 1'b1;
		rvalid = 1'b0;
		rlast = 1'b0;
		rresp = '0;
		rdata = '0;
		forever begin
			next_cycle();
			if (arvalid) begin
				addr = araddr;
				n = reads_seen - reads_base;
				reads_seen++;
				line = fill_line(addr);
				if (n == 0) begin
					att_ar_cyc = cyc;
					assert (addr == exp_att_addr) else report_mismatch(
						$sformatf("ATT address %h, expected %h", addr, exp_att_addr));
					line[64*att_word +: 64] = att_entry;
				end else begin
					lst_ar_cyc = cyc;
					assert (addr == exp_lst_addr) else report_mismatch(
						$sformatf("list address %h, expected %h", addr, exp_lst_addr));
					line[128*lst_slot +: 128] = exp_lst_entry;
				end
				if (!drop_rsp) begin
					repeat (RSP_DELAY) next_cycle();
					rvalid = 1'b1;
					rlast = 1'b1;
					rresp = rsp_code;
					rdata = swap_line(line);
					if (n == 0)
						att_beat_cyc = cyc;
					else
						lst_beat_cyc = cyc;
					next_cycle();
					rvalid = 1'b0;
					rlast = 1'b0;
					rresp = '0;
				end
			end
		end
	end

	task automatic apply_reset();
		rst_ni = 1'b0;
		lookup = 1'b0;
		pgwr_mngr_ready = 1'b1;
		drop_rsp = 1'b0;
		rsp_code = '0;
		repeat (4) next_cycle();
		rst_ni = 1'b1;
		next_cycle();
		assert (pgrd_mngr_ready && !bus_error && !arvalid && rready)
			else report_error("ready, bus_error, arvalid or rready wrong after reset");
		assert (!allow_access && !tbl_update)
			else report_error("output pulse active after reset");
	endtask

	// host page inside the ATT, entry placed at word w of its line
	task automatic prepare_att(input logic [2:0] w, input att_sts_t s);
		logic [31:0] r;
		int off;
		r = next_random();
		off = int'({r[14:3], w});
		hppa = HPPA_BASE_PAGE + hppa_t'(off);
		exp_att_id = att_id_t'(off + 1);
		exp_att_addr = HAWK_ATT_START + axi_addr_t'(off / 8) * 64'd64;
		att_word = w;
		exp_sts = s;
		exp_ppa = ppa_t'({next_random(), next_random()});
		att_entry = {next_random(), next_random()};
		att_entry[63:62] = s;
		att_entry[49:2] = exp_ppa;
	endtask

	// head picks one of four 128-bit slots, tail equal to head means empty
	task automatic prepare_list(input logic [1:0] low, input logic empty);
		logic [31:0] r;
		int hm1;
		r = next_random();
		free_lst_head = {r[11:0] | 12'h1, low};
		free_lst_tail = empty ? free_lst_head : free_lst_head + lst_id_t'(7);
		hm1 = int'(free_lst_head) - 1;
		exp_lst_addr = HAWK_LIST_START + axi_addr_t'(hm1 / 4) * 64'd64;
		lst_slot = 2'(hm1 % 4);
		exp_lst_entry = {next_random(), next_random(), next_random(), next_random()};
	endtask

	task automatic issue_lookup();
		assert (pgrd_mngr_ready) else report_error("manager not ready for a new lookup");
		reads_base = reads_seen;
		lookup = 1'b1;
		next_cycle();
		lookup = 1'b0;
	endtask

	task automatic check_packet();
		assert (upd_att_id == exp_att_id) else report_mismatch(
			$sformatf("upd_att_id %0d, expected %0d", upd_att_id, exp_att_id));
		assert (upd_tol_id == free_lst_head) else report_mismatch(
			$sformatf("upd_tol_id %0d, expected %0d", upd_tol_id, free_lst_head));
		assert (upd_src_list == FREE && upd_dst_list == UNCOMP) else report_mismatch(
			$sformatf("lists %0d to %0d, expected FREE to UNCOMP", upd_src_list, upd_dst_list));
		assert (upd_lst_entry == exp_lst_entry) else report_mismatch(
			$sformatf("list entry %h, expected %h", upd_lst_entry, exp_lst_entry));
		assert (reads_seen - reads_base == 2)
			else report_error("allocation did not take exactly two reads");
	endtask

	// n quiet cycles with fixed ready and bus_error levels
	task automatic hold_check(input int n, input logic exp_ready, input logic exp_err);
		repeat (n) begin
			next_cycle();
			assert (pgrd_mngr_ready == exp_ready && bus_error == exp_err) else report_mismatch(
				$sformatf("ready %b bus_error %b, expected %b %b",
				pgrd_mngr_ready, bus_error, exp_ready, exp_err));
			assert (!tbl_update && !allow_access)
				else report_error("unexpected tbl_update or allow_access pulse");
		end
	endtask

	task automatic test_hit();
		int n;
		apply_reset();
		for (int w = 0; w < 8; w++) begin
			prepare_att(3'(w), w[0] ? STS_INCOMP : STS_UNCOMP);
			issue_lookup();
			n = 0;
			while (!allow_access && n < REQ_CYCLES) begin
				next_cycle();
				n++;
			end
			assert (allow_access) else report_error("no allow_access pulse after a hit");
			assert (cyc == att_beat_cyc + 2) else report_mismatch(
				$sformatf("allow_access %0d cycles after the beat", cyc - att_beat_cyc));
			assert (ppa == exp_ppa && sts == exp_sts) else report_mismatch(
				$sformatf("ppa %h sts %0d, expected %h %0d", ppa, sts, exp_ppa, exp_sts));
			assert (pgrd_mngr_ready) else report_error("manager not idle with allow_access");
			next_cycle();
			// translation stays on the outputs after the pulse
			assert (!allow_access && ppa == exp_ppa)
				else report_error("allow_access longer than one cycle or ppa lost");
			assert (reads_seen - reads_base == 1) else report_error("extra read after a hit");
		end
	endtask

	task automatic test_allocate();
		int n;
		apply_reset();
		for (int k = 0; k < 4; k++) begin
			prepare_att(3'(next_random()), STS_DALLOC);
			prepare_list(2'(k), 1'b0);
			issue_lookup();
			n = 0;
			while (!tbl_update && n < REQ_CYCLES) begin
				next_cycle();
				n++;
			end
			assert (tbl_update) else report_error("no tbl_update after a free-list pop");
			assert (lst_ar_cyc == att_beat_cyc + 3) else report_mismatch(
				$sformatf("list read %0d cycles after ATT beat", lst_ar_cyc - att_beat_cyc));
			assert (cyc == lst_beat_cyc + 2) else report_mismatch(
				$sformatf("tbl_update %0d cycles after list beat", cyc - lst_beat_cyc));
			check_packet();
			next_cycle();
			assert (!tbl_update && pgrd_mngr_ready)
				else report_error("tbl_update too long or manager not idle");
		end
	endtask

	task automatic test_backpressure();
		apply_reset();
		prepare_att(3'd5, STS_DALLOC);
		prepare_list(2'd2, 1'b0);
		pgwr_mngr_ready = 1'b0;
		issue_lookup();
		hold_check(HOLD_CYCLES, 1'b0, 1'b0);
		assert (reads_seen - reads_base == 2)
			else report_error("list read missing under back-pressure");
		pgwr_mngr_ready = 1'b1;
		next_cycle();
		assert (tbl_update) else report_error("no tbl_update in the cycle after ready rose");
		check_packet();
		next_cycle();
		assert (!tbl_update) else report_error("tbl_update longer than one cycle");
	endtask

	task automatic test_empty_list();
		int n;
		apply_reset();
		prepare_att(3'd2, STS_DALLOC);
		prepare_list(2'd1, 1'b1);
		issue_lookup();
		n = 0;
		while (!pgrd_mngr_ready && n < REQ_CYCLES) begin
			next_cycle();
			n++;
			assert (!tbl_update) else report_error("tbl_update with an empty free list");
		end
		assert (pgrd_mngr_ready) else report_error("no return to idle on an empty free list");
		hold_check(HOLD_CYCLES, 1'b1, 1'b0);
		assert (reads_seen - reads_base == 1)
			else report_error("list read issued with an empty free list");
	endtask

	task automatic test_compressed();
		apply_reset();
		prepare_att(3'd7, STS_COMP);
		issue_lookup();
		// parked until reset, no second request
		hold_check(HOLD_CYCLES, 1'b0, 1'b0);
		assert (reads_seen - reads_base == 1) else report_error("read after a compressed entry");
		apply_reset();
	endtask

	task automatic test_bus_errors();
		int n;
		// slave error on the ATT read
		apply_reset();
		prepare_att(3'd3, STS_UNCOMP);
		rsp_code = 2'b10;
		issue_lookup();
		n = 0;
		while (!bus_error && n < REQ_CYCLES) begin
			next_cycle();
			n++;
		end
		assert (bus_error) else report_error("no bus_error after an error response");
		hold_check(HOLD_CYCLES, 1'b0, 1'b1);
		// no response at all
		apply_reset();
		prepare_att(3'd4, STS_UNCOMP);
		drop_rsp = 1'b1;
		issue_lookup();
		n = 0;
		while (!bus_error && n < int'(RD_TIMEOUT_CYCLES) + REQ_CYCLES) begin
			next_cycle();
			n++;
		end
		assert (bus_error) else report_error("no bus_error after a missing response");
		assert (cyc > att_ar_cyc + int'(RD_TIMEOUT_CYCLES)
			&& cyc <= att_ar_cyc + int'(RD_TIMEOUT_CYCLES) + 2) else report_mismatch(
			$sformatf("bus_error %0d cycles after the request", cyc - att_ar_cyc));
		hold_check(HOLD_CYCLES, 1'b0, 1'b1);
		apply_reset();
	endtask

	// run limit on the clock count
	initial begin : watchdog
		while (cyc < RUN_LIMIT) begin
			@(posedge clk_i);
			cyc++;
		end
		$display("ERROR: run did not finish within %0d cycles", RUN_LIMIT);
		$display("errors: %0d", errors);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main
		seed = 32'hc999;
		rst_ni = 1'b0;
		lookup = 1'b0;
		hppa = '0;
		pgwr_mngr_ready = 1'b1;
		free_lst_head = '0;
		free_lst_tail = '0;
		drop_rsp = 1'b0;
		rsp_code = '0;
		test_hit();
		test_allocate();
		test_backpressure();
		test_empty_list();
		test_compressed();
		test_bus_errors();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/hacd_pkg.sv
hw/axi_rd_if.sv
hw/pgrd_fsm.sv
hw/rd_timeout_timer.sv
hw/pgrd_datapath.sv
hw/hawk_pgrd_mngr.sv
tb/tb_hawk_pgrd_mngr.sv

// File: Makefile
# Verilator build and run of the page-read manager testbench

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
LINT     ?= --lint-only -Wall --timing
TOP      ?= tb_hawk_pgrd_mngr
FILELIST ?= list.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides pass or fail
run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
